// ==== dv/dram_props.sv ====
// DRAM model protocol assertions
`timescale 1ns/10ps

module dram_props
(
	input logic clk,
	input logic arst_n,
	input logic req_valid,  // Request strobe from the requester
	input logic req_credit, // Credit pulse back to the requester
	input logic pop,        // Queue head retired by the scheduler
	input logic rd_en,      // Read access cycle
	input logic rsp_valid   // Read data valid
);

	dram_pkg::qcnt_t occ; // Queue occupancy rebuilt from the port traffic
	logic            full;

	assign full = (occ == dram_pkg::qcnt_t'(dram_pkg::REQ_CREDITS));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			occ <= '0;
		end
		else
		begin
			case ({req_valid && !full, pop && (occ != '0)})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ; // Push and pop together keep the level
			endcase
		end
	end

	// A full queue means every credit is spent
	no_req_when_full: assert property (@(posedge clk) disable iff (!arst_n)
		full |-> !req_valid)
		else $error("request sent while the queue was full");

	rsp_after_read: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid |-> $past(rd_en))
		else $error("response without a read access in the previous cycle");

	quiet_in_reset: assert property (@(posedge clk)
		!arst_n |-> (!rsp_valid && !req_credit))
		else $error("outputs active during reset");

endmodule

bind dram_model_top dram_props u_dram_props (
	.clk        (clk),
	.arst_n     (arst_n),
	.req_valid  (req_valid),
	.req_credit (req_credit),
	.pop        (pop),
	.rd_en      (rd_en),
	.rsp_valid  (rsp_valid)
);

// ==== dv/dram_tb.sv ====
// DRAM model testbench
`timescale 1ns/10ps

module dram_tb;

	logic                clk;
	logic                arst_n;
	logic                req_valid;
	dram_pkg::dram_req_t req;
	logic                req_credit;
	logic                rsp_valid;
	dram_pkg::data_t     rsp_data;
	logic                rsp_credit;

	int wait_limit = 2000;         // Cycles any single wait may last
	int seed       = 32'h97a62a60; // Fixed seed for the random traffic
	int credits;                   // Request credits held by the requester
	int issued;                    // Requests sent so far
	int credit_pulses;             // req_credit pulses seen so far
	int rsp_count;                 // Responses seen so far
	int pending;                   // Responses taken whose credit is not back yet
	bit hold_credits;              // Consumer keeps response credits while set
	int checks;
	int errors;

	event timed_out;               // Raised by a wait that gave up

	dram_pkg::data_t shadow [int]; // Reference memory keyed by folded index
	dram_pkg::data_t exp_q [$];    // Expected read data in request order
	dram_pkg::data_t exp_data;

	dram_model_top u_dram_model_top (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.req_credit (req_credit),
		.rsp_valid  (rsp_valid),
		.rsp_data   (rsp_data),
		.rsp_credit (rsp_credit)
	);

	always #4 clk = ~clk; // 8 ns period

	// Storage index from bank bits 34:32, row bits 20:16 and column bits 7:0
	function automatic int ref_index(input dram_pkg::addr_t a);
		logic [15:0] idx;
		idx = {a[34:32], a[20:16], a[7:0]};
		return int'(idx);
	endfunction

	function automatic dram_pkg::data_t ref_read(input dram_pkg::addr_t a);
		return shadow[ref_index(a)]; // Last data written to the same folded index
	endfunction

	function automatic dram_pkg::addr_t make_addr(input dram_pkg::addr_t junk, input int b,
		input int r, input int c);
		dram_pkg::addr_t a;
		a = junk; // Bits outside the fields stay as given
		a[34:32] = 3'(b);
		a[20:16] = 5'(r);
		a[7:0]   = 8'(c);
		return a;
	endfunction

	task automatic check(input bit ok, input string msg);
		checks++;
		assert (ok) else
		begin
			errors++;
			$display("FAILED t=%0t %s", $time, msg);
		end
	endtask

	task automatic abort(input string why);
		$display("Timed out while waiting for %s", why);
		-> timed_out;
		forever @(negedge clk); // Caller stays parked until the run ends
	endtask

	// A wait that gave up ends the run as a failure
	always @(timed_out)
	begin
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic report(input string name, input int err_start);
		if (errors == err_start)
		begin
			$display("test %s: ok", name);
		end
		else
		begin
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	// One request per credit, entered and left on a falling edge
	task automatic send(input bit wr, input dram_pkg::addr_t a, input dram_pkg::data_t d);
		int n;
		n = 0;
		while (credits == 0 && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (credits == 0)
		begin
			abort("a request credit");
		end
		credits--;
		issued++;
		if (wr)
		begin
			shadow[ref_index(a)] = d; // Writes land in order ahead of later reads
		end
		else
		begin
			exp_q.push_back(ref_read(a));
		end
		req.write = wr;
		req.addr  = a;
		req.data  = d;
		req_valid = 1'b1;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_drain(input string what);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || pending != 0 || credits != dram_pkg::REQ_CREDITS)
			&& n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (n >= wait_limit)
		begin
			abort(what);
		end
	endtask

	task automatic wait_rsp(input int target, input string what);
		int n;
		n = 0;
		while (rsp_count < target && n < wait_limit)
		begin
			@(negedge clk);
			n++;
		end
		if (rsp_count < target)
		begin
			abort(what);
		end
	endtask

	// Credits come back one per freed queue entry
	always @(posedge clk)
	begin
		if (req_credit)
		begin
			check(credit_pulses < issued, "req_credit pulse with no request outstanding");
			credits++;
			credit_pulses++;
		end
	end

	// In order comparison of read data against the reference
	always @(posedge clk)
	begin
		if (rsp_valid)
		begin
			rsp_count++;
			pending++;
			check(exp_q.size() != 0, "response arrived with no read outstanding");
			if (exp_q.size() != 0)
			begin
				exp_data = exp_q.pop_front();
				check(rsp_data === exp_data,
					$sformatf("read data %02h expected %02h", rsp_data, exp_data));
			end
		end
	end

	always @(negedge clk)
	begin
		if (pending > 0 && !hold_credits)
		begin
			rsp_credit = 1'b1; // One credit per taken response
			pending--;
		end
		else
		begin
			rsp_credit = 1'b0;
		end
	end

	initial
	begin
		int              err_start;
		int              base;
		int              i;
		logic [31:0]     rnd;
		logic [63:0]     junk;
		dram_pkg::addr_t a;
		clk           = 1'b0;
		arst_n        = 1'b0;
		req_valid     = 1'b0;
		req           = '0;
		rsp_credit    = 1'b0;
		credits       = dram_pkg::REQ_CREDITS;
		issued        = 0;
		credit_pulses = 0;
		rsp_count     = 0;
		pending       = 0;
		hold_credits  = 1'b0;
		checks        = 0;
		errors        = 0;

		err_start = errors;
		repeat (3)
		begin
			@(negedge clk);
			check(!req_credit && !rsp_valid, "req_credit or rsp_valid high during reset");
		end
		arst_n = 1'b1;
		repeat (2)
		begin
			@(negedge clk);
			check(!req_credit && !rsp_valid, "req_credit or rsp_valid high while idle");
		end
		a = make_addr('0, 0, 1, 8'h10);
		send(1'b1, a, 8'h5a);
		send(1'b0, a, 8'h00);
		wait_drain("write then read");
		report("reset_and_readback", err_start);

		err_start = errors;
		send(1'b1, make_addr(36'h8_0000_0000, 5, 7, 8'h42), 8'ha5);
		send(1'b0, make_addr(36'h0_ffe0_ff00, 5, 7, 8'h42), 8'h00); // Ignored bits differ
		wait_drain("aliased read");
		report("aliasing", err_start);

		err_start = errors;
		send(1'b1, make_addr('0, 1, 2, 10), 8'h11);
		send(1'b1, make_addr('0, 1, 2, 11), 8'h22); // Row hit
		send(1'b1, make_addr('0, 2, 0, 5), 8'h33);  // Closed bank
		send(1'b1, make_addr('0, 1, 3, 7), 8'h44);  // Row conflict
		send(1'b0, make_addr('0, 1, 2, 10), 8'h00);
		send(1'b0, make_addr('0, 2, 0, 5), 8'h00);
		send(1'b0, make_addr('0, 1, 3, 7), 8'h00);
		send(1'b0, make_addr('0, 1, 2, 11), 8'h00);
		wait_drain("bank and row cases");
		report("bank_row_cases", err_start);

		err_start = errors;
		base = rsp_count;
		for (i = 0; i < 16; i++)
		begin
			send(i < 8, make_addr('0, 3, i % 2, i % 8), 8'(8'h60 + i)); // Conflicts fill the FIFO
		end
		wait_rsp(base + 8, "burst reads"); // Last read's credit comes with its response
		check(credit_pulses == issued, $sformatf("credit pulses %0d for %0d requests",
			credit_pulses, issued));
		wait_drain("burst traffic");
		report("credits", err_start);

		err_start = errors;
		hold_credits = 1'b1;
		base = rsp_count;
		for (i = 0; i < 5; i++)
		begin
			send(1'b0, make_addr('0, 3, i % 2, i), 8'h00);
		end
		wait_rsp(base + dram_pkg::RSP_CREDITS, "responses under back-pressure");
		repeat (20)
		begin
			@(negedge clk);
			check(rsp_count - base <= dram_pkg::RSP_CREDITS, "response beyond the credits");
		end
		hold_credits = 1'b0;
		wait_drain("reads after credits returned");
		report("backpressure", err_start);

		err_start = errors;
		for (i = 0; i < 300; i++)
		begin
			rnd  = $random(seed);
			junk = {$random(seed), $random(seed)};
			a    = make_addr(junk[35:0], int'(rnd[1:0]), int'(rnd[3:2]), int'(rnd[6:4]));
			if (rnd[8] || !shadow.exists(ref_index(a)))
			begin
				send(1'b1, a, rnd[23:16]);
			end
			else
			begin
				send(1'b0, a, 8'h00);
			end
		end
		wait_drain("random traffic");
		report("random", err_start);

		$display("checks %0d errors %0d responses %0d", checks, errors, rsp_count);
		if (errors == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
rtl/dram_pkg.sv
rtl/dport_ram.sv
rtl/req_queue.sv
rtl/bank_tracker.sv
rtl/access_sched.sv
rtl/dram_model_top.sv
dv/dram_props.sv
dv/dram_tb.sv

// ==== rtl/access_sched.sv ====
// Bank timing scheduler
`timescale 1ns/10ps

module access_sched
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 head_valid, // Queue head is present
	input  dram_pkg::dram_req_t  head,       // Request at the head
	input  dram_pkg::row_class_t row_class,  // Tracker verdict for the head
	output logic                 pop,        // Head done, free its entry
	output logic                 open_row,   // Activate finished
	output logic                 close_row,  // Precharge finished
	output logic                 we,         // Storage write strobe
	output logic                 rd_en,      // Storage read strobe
	output dram_pkg::ram_idx_t   write_idx,
	output dram_pkg::ram_idx_t   read_idx,
	output dram_pkg::data_t      di,
	input  logic                 rsp_credit, // Consumer took one response
	output logic                 rsp_valid   // Read data is on the storage output
);

	dram_pkg::sched_state_t state;
	dram_pkg::dly_t         dly;     // Cycles left in precharge or activate
	dram_pkg::rcrd_t        rsp_cnt; // Response credits on hand

	logic start;

	// A read may only start while a response slot is guaranteed
	assign start = head_valid && (head.write || (rsp_cnt != '0));

	// Storage and tracker controls decode straight from the state
	assign pop       = (state == dram_pkg::ST_ACCESS);
	assign we        = pop && head.write;
	assign rd_en     = pop && !head.write;                                  // Spends a credit
	assign close_row = (state == dram_pkg::ST_PRECHARGE) && (dly == '0);    // Last precharge cycle
	assign open_row  = (state == dram_pkg::ST_ACTIVATE) && (dly == '0);     // Last activate cycle
	assign write_idx = dram_pkg::fold_idx(head.addr);
	assign read_idx  = dram_pkg::fold_idx(head.addr);
	assign di        = head.data;

	// State machine with its delay counter
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= dram_pkg::ST_IDLE;
			dly   <= '0;
		end
		else
		begin
			case (state)
				dram_pkg::ST_IDLE:
				begin
					if (start)
					begin
						case (row_class)
							dram_pkg::RC_HIT: state <= dram_pkg::ST_ACCESS; // Next cycle
							dram_pkg::RC_CLOSED:
							begin
								state <= dram_pkg::ST_ACTIVATE;
								dly   <= dram_pkg::dly_t'(dram_pkg::T_RCD - 1); // T_RCD cycles
							end
							default:
							begin
								state <= dram_pkg::ST_PRECHARGE;
								dly   <= dram_pkg::dly_t'(dram_pkg::T_RP - 1); // T_RP cycles
							end
						endcase
					end
				end
				dram_pkg::ST_PRECHARGE:
				begin
					if (dly == '0)
					begin
						state <= dram_pkg::ST_ACTIVATE; // Bank is closed, now open the new row
						dly   <= dram_pkg::dly_t'(dram_pkg::T_RCD - 1);
					end
					else
					begin
						dly <= dly - 1'b1;
					end
				end
				dram_pkg::ST_ACTIVATE:
				begin
					if (dly == '0)
					begin
						state <= dram_pkg::ST_ACCESS;
					end
					else
					begin
						dly <= dly - 1'b1;
					end
				end
				default: state <= dram_pkg::ST_IDLE; // Access lasts a single cycle
			endcase
		end
	end

	// Response credits and the registered response strobe
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rsp_cnt   <= dram_pkg::rcrd_t'(dram_pkg::RSP_CREDITS);
			rsp_valid <= 1'b0;
		end
		else
		begin
			case ({rd_en, rsp_credit})
				2'b10:   rsp_cnt <= rsp_cnt - 1'b1; // Read started
				2'b01:   rsp_cnt <= rsp_cnt + 1'b1; // Consumer freed a slot
				default: rsp_cnt <= rsp_cnt;
			endcase
			rsp_valid <= rd_en; // Matches the one cycle storage latency
		end
	end

endmodule

// ==== rtl/bank_tracker.sv ====
// Per bank open row tracking
`timescale 1ns/10ps

module bank_tracker
(
	input  logic                 clk,
	input  logic                 arst_n,
	input  dram_pkg::addr_t      head_addr, // Address of the queue head
	input  logic                 open_row,  // Activate the head's row in its bank
	input  logic                 close_row, // Precharge the head's bank
	output dram_pkg::row_class_t row_class  // How the head relates to the open row
);

	logic [dram_pkg::NUM_BANKS-1:0] bank_open;            // Bank has a row open
	dram_pkg::row_t                 open_rows [dram_pkg::NUM_BANKS]; // Row held open per bank

	dram_pkg::bank_t head_bank;
	dram_pkg::row_t  head_row;

	assign head_bank = dram_pkg::bank_of(head_addr); // Same field rule as the storage fold
	assign head_row  = dram_pkg::row_of(head_addr);

	// Classification of the head request
	always_comb
	begin
		if (!bank_open[head_bank])
		begin
			row_class = dram_pkg::RC_CLOSED; // Needs an activate only
		end
		else if (open_rows[head_bank] == head_row)
		begin
			row_class = dram_pkg::RC_HIT; // Goes straight to the access
		end
		else
		begin
			row_class = dram_pkg::RC_CONFLICT; // Other row open, precharge first
		end
	end

	// Open flags are control state and all banks start closed
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bank_open <= '0;
		end
		else
		begin
			if (open_row)
			begin
				bank_open[head_bank] <= 1'b1;
			end
			else if (close_row)
			begin
				bank_open[head_bank] <= 1'b0;
			end
		end
	end

	// Row numbers only matter while the open flag is set
	always_ff @(posedge clk)
	begin
		if (open_row)
		begin
			open_rows[head_bank] <= head_row; // Remember which row the bank now holds
		end
	end

endmodule

// ==== rtl/dport_ram.sv ====
// Single clock storage array
`timescale 1ns/10ps

module dport_ram
(
	input  logic               clk,
	input  logic               we,        // Write strobe, wins over a read
	input  dram_pkg::ram_idx_t write_idx, // Folded write index
	input  dram_pkg::ram_idx_t read_idx,  // Folded read index
	input  dram_pkg::data_t    di,        // Write data
	input  logic               rd_en,     // Read strobe
	output dram_pkg::data_t    dout       // Registered read data
);

	// Whole folded space, one byte per index
	dram_pkg::data_t mem [dram_pkg::RAM_WORDS];

	// Write side
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[write_idx] <= di; // Store the byte at the folded index
		end
	end

	// Read side holds its last value unless a plain read is requested
	always_ff @(posedge clk)
	begin
		if (!we && rd_en)
		begin
			dout <= mem[read_idx]; // Data shows up one cycle after rd_en
		end
	end

endmodule

// ==== rtl/dram_model_top.sv ====
// Banked DRAM behavioral model
`timescale 1ns/10ps

module dram_model_top
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic                req_valid,  // Request strobe, credit backed
	input  dram_pkg::dram_req_t req,
	output logic                req_credit, // One pulse per freed queue entry
	output logic                rsp_valid,  // Read data valid
	output dram_pkg::data_t     rsp_data,
	input  logic                rsp_credit  // Consumer returns a response slot
);

	logic                 head_valid;
	dram_pkg::dram_req_t  head;
	logic                 pop;
	dram_pkg::row_class_t row_class;
	logic                 open_row;
	logic                 close_row;
	logic                 we;
	logic                 rd_en;
	dram_pkg::ram_idx_t   write_idx;
	dram_pkg::ram_idx_t   read_idx;
	dram_pkg::data_t      di;

	// Requests wait here in arrival order
	req_queue u_req_queue (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid  (req_valid),
		.req        (req),
		.pop        (pop),
		.head_valid (head_valid),
		.head       (head),
		.req_credit (req_credit)
	);

	// Open row state seen by the head
	bank_tracker u_bank_tracker (
		.clk       (clk),
		.arst_n    (arst_n),
		.head_addr (head.addr),
		.open_row  (open_row),
		.close_row (close_row),
		.row_class (row_class)
	);

	access_sched u_access_sched (
		.clk        (clk),
		.arst_n     (arst_n),
		.head_valid (head_valid),
		.head       (head),
		.row_class  (row_class),
		.pop        (pop),
		.open_row   (open_row),
		.close_row  (close_row),
		.we         (we),
		.rd_en      (rd_en),
		.write_idx  (write_idx),
		.read_idx   (read_idx),
		.di         (di),
		.rsp_credit (rsp_credit),
		.rsp_valid  (rsp_valid)
	);

	// Storage output is the response data directly
	dport_ram u_dport_ram (
		.clk       (clk),
		.we        (we),
		.write_idx (write_idx),
		.read_idx  (read_idx),
		.di        (di),
		.rd_en     (rd_en),
		.dout      (rsp_data)
	);

endmodule

// ==== rtl/dram_pkg.sv ====
// Banked DRAM model definitions
package dram_pkg;

	localparam int BANK_W = 3;                         // Bank field width
	localparam int ROW_W  = 5;                         // Row bits kept by the model
	localparam int COL_W  = 8;                         // Column field width
	localparam int BANK_LSB = 32;                      // Bank sits at address bits 34 to 32
	localparam int ROW_LSB  = 16;                      // Row starts at address bit 16
	localparam int COL_LSB  = 0;                       // Column is the low address byte
	localparam int IDX_W     = BANK_W + ROW_W + COL_W; // Folded index width
	localparam int RAM_WORDS = 1 << IDX_W;             // One word per folded index
	localparam int NUM_BANKS = 8;                      // Banks with their own open row

	localparam int T_RP  = 3;                          // Precharge delay in cycles
	localparam int T_RCD = 2;                          // Activate to access delay in cycles
	localparam int REQ_CREDITS = 4;                    // Request credits, also queue depth
	localparam int RSP_CREDITS = 2;                    // Response credits held by the scheduler

	localparam int DLY_W  = $clog2((T_RP > T_RCD) ? T_RP : T_RCD); // Delay counter width
	localparam int QPTR_W = $clog2(REQ_CREDITS);       // Queue pointer width
	localparam int QCNT_W = $clog2(REQ_CREDITS + 1);   // Queue occupancy width
	localparam int RCRD_W = $clog2(RSP_CREDITS + 1);   // Response credit counter width

	typedef logic [35:0]        addr_t;                // Requester address
	typedef logic [7:0]         data_t;                // Storage word
	typedef logic [BANK_W-1:0]  bank_t;
	typedef logic [ROW_W-1:0]   row_t;
	typedef logic [COL_W-1:0]   col_t;
	typedef logic [IDX_W-1:0]   ram_idx_t;             // Bank, then row, then column
	typedef logic [DLY_W-1:0]   dly_t;
	typedef logic [QPTR_W-1:0]  qptr_t;
	typedef logic [QCNT_W-1:0]  qcnt_t;
	typedef logic [RCRD_W-1:0]  rcrd_t;

	typedef struct packed {
		logic  write;                                  // High for a write, low for a read
		addr_t addr;
		data_t data;                                   // Unused on reads
	} dram_req_t;

	typedef enum logic [1:0] {ST_IDLE, ST_PRECHARGE, ST_ACTIVATE, ST_ACCESS} sched_state_t;

	typedef enum logic [1:0] {RC_HIT, RC_CLOSED, RC_CONFLICT} row_class_t;

	function automatic bank_t bank_of(input addr_t addr);
		return addr[BANK_LSB +: BANK_W];               // Same bits as a real part
	endfunction

	function automatic row_t row_of(input addr_t addr);
		return addr[ROW_LSB +: ROW_W];                 // Upper row bits alias
	endfunction

	function automatic col_t col_of(input addr_t addr);
		return addr[COL_LSB +: COL_W];
	endfunction

	function automatic ram_idx_t fold_idx(input addr_t addr);
		return {bank_of(addr), row_of(addr), col_of(addr)}; // Bits outside the fields are dropped
	endfunction

endpackage

// ==== rtl/req_queue.sv ====
// Request FIFO with credit return
`timescale 1ns/10ps

module req_queue
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic                req_valid,  // One request per pulse, backed by a credit
	input  dram_pkg::dram_req_t req,        // Incoming request
	input  logic                pop,        // Scheduler finished the head
	output logic                head_valid, // Queue holds at least one request
	output dram_pkg::dram_req_t head,       // Oldest request
	output logic                req_credit  // One pulse per freed entry
);

	// Entries carry payload only and need no reset
	dram_pkg::dram_req_t entries [dram_pkg::REQ_CREDITS];

	dram_pkg::qptr_t wr_ptr; // Next slot to fill
	dram_pkg::qptr_t rd_ptr; // Slot of the head
	dram_pkg::qcnt_t count;  // Occupied slots

	logic full;
	logic push;
	logic do_pop;

	assign full   = (count == dram_pkg::qcnt_t'(dram_pkg::REQ_CREDITS)); // All credits spent
	assign push   = req_valid && !full;   // A request beyond the credits is dropped
	assign do_pop = pop && head_valid;    // Never pop an empty queue

	assign head_valid = (count != '0);
	assign head       = entries[rd_ptr];  // Head is visible the cycle after its push

	// Payload write
	always_ff @(posedge clk)
	begin
		if (push)
		begin
			entries[wr_ptr] <= req;
		end
	end

	// Pointers, occupancy and the credit pulse
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			req_credit <= 1'b0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two so it wraps on its own
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither leave occupancy unchanged
			endcase
			req_credit <= do_pop; // Credit goes back one cycle after the pop
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module dram_tb -o dram_sim

out="$(./obj_dir/dram_sim)"
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
else
	exit 1
fi
